/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tbFemtoCore
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
hdl/rvIsaPkg.sv
hdl/coreCfgPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/controlSeq.sv
hdl/femtoCore.sv
testbench/femtoCore_properties.sv
testbench/tbFemtoCore.sv

/* hdl/alu.sv */
// ALU with shared subtractor, multi-cycle shifter and branch predicate
`default_nettype none

module alu (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        aluWr,    // Load operands and start
   input  logic [coreCfgPkg::xlen-1:0] in1,
   input  logic [coreCfgPkg::xlen-1:0] in2,
   input  rvIsaPkg::aluFnT             funct3,
   input  logic                        subSra,
   input  logic                        isAluReg,
   output logic [coreCfgPkg::xlen-1:0] aluOut,
   output logic [coreCfgPkg::xlen-1:0] aluPlus,
   output logic                        aluBusy,
   output logic                        predicate
);

   logic [coreCfgPkg::xlen-1:0]   aluReg;   // Result and shift register
   logic [coreCfgPkg::shamtW-1:0] aluShamt; // Steps still to go
   logic [coreCfgPkg::xlen:0]     aluMinus; // One extra bit for borrow
   logic                          lt;
   logic                          ltu;
   logic                          eq;

   assign aluPlus = in1 + in2; // Also used for load, store and JALR addresses

   // ******************************
   // Subtract and compare
   // ******************************
   assign aluMinus = {1'b1, ~in2} + {1'b0, in1} + 1'b1;
   assign ltu      = aluMinus[coreCfgPkg::xlen];
   // Signs differ so in1 is less exactly when it is negative
   assign lt  = (in1[coreCfgPkg::xlen-1] ^ in2[coreCfgPkg::xlen-1]) ?
                in1[coreCfgPkg::xlen-1] : ltu;
   assign eq  = (aluMinus[coreCfgPkg::xlen-1:0] == '0);

   assign aluOut  = aluReg;
   assign aluBusy = |aluShamt; // Busy while shifting

   // ******************************
   // Result register and shifter
   // ******************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         aluShamt <= '0;
      end else if (aluWr) begin
         case (funct3)
            rvIsaPkg::fnAdd: begin
               // Immediate form uses bit 30 as part of the immediate
               aluReg <= (subSra && isAluReg) ? aluMinus[coreCfgPkg::xlen-1:0] : aluPlus;
            end
            rvIsaPkg::fnSlt:  aluReg <= {{(coreCfgPkg::xlen-1){1'b0}}, lt};
            rvIsaPkg::fnSltu: aluReg <= {{(coreCfgPkg::xlen-1){1'b0}}, ltu};
            rvIsaPkg::fnXor:  aluReg <= in1 ^ in2;
            rvIsaPkg::fnOr:   aluReg <= in1 | in2;
            rvIsaPkg::fnAnd:  aluReg <= in1 & in2;
            rvIsaPkg::fnSll, rvIsaPkg::fnSrx: begin
               aluReg   <= in1;                       // Value to shift
               aluShamt <= in2[coreCfgPkg::shamtW-1:0]; // Amount from rs2 or imm
            end
            default: aluReg <= aluPlus;
         endcase
      end else if (|aluShamt) begin
         // One bit per cycle
         aluShamt <= aluShamt - 1'b1;
         if (funct3 == rvIsaPkg::fnSll) begin
            aluReg <= aluReg << 1;
         end else begin
            aluReg <= {subSra & aluReg[coreCfgPkg::xlen-1], aluReg[coreCfgPkg::xlen-1:1]};
         end
      end
   end

   // ******************************
   // Branch predicate
   // ******************************
   always_comb begin
      case (rvIsaPkg::branchFnT'(funct3))
         rvIsaPkg::brEq:  predicate = eq;
         rvIsaPkg::brNe:  predicate = !eq;
         rvIsaPkg::brLt:  predicate = lt;
         rvIsaPkg::brGe:  predicate = !lt;
         rvIsaPkg::brLtu: predicate = ltu;
         rvIsaPkg::brGeu: predicate = !ltu;
         default:         predicate = 1'b0; // Not a branch code
      endcase
   end

endmodule

`default_nettype wire

/* hdl/controlSeq.sv */
// One-hot control sequencer owning PC, memory address and instruction latch
`default_nettype none

module controlSeq #(
   parameter logic [coreCfgPkg::xlen-1:0] resetAddr = '0
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [coreCfgPkg::xlen-1:0] memRdata,
   input  logic                        memRbusy,
   input  logic                        memWbusy,
   input  rvIsaPkg::opcodeT            opcode,
   input  logic [coreCfgPkg::xlen-1:0] immB,
   input  logic [coreCfgPkg::xlen-1:0] immJ,
   input  logic [coreCfgPkg::xlen-1:0] immU,
   input  logic [coreCfgPkg::xlen-1:0] aluPlus,
   input  logic                        aluBusy,
   input  logic                        predicate,
   output logic [coreCfgPkg::xlen-1:0] instr,
   output logic [coreCfgPkg::xlen-1:0] pc,
   output logic [coreCfgPkg::xlen-1:0] pcPlus4,
   output logic [coreCfgPkg::xlen-1:0] branchTarget,
   output logic [coreCfgPkg::xlen-1:0] memAddr,
   output logic                        memRstrb,
   output logic [3:0]                  memWmask,
   output logic                        aluWr,
   output logic                        writeBack
);

   coreCfgPkg::stateT state;
   logic              isLoad;
   logic              isAluOp;  // Register or immediate ALU operation
   logic              isStore;
   logic              isBranch;
   logic              isJalr;
   logic              isJal;
   logic              isAuipc;
   logic              isLui;
   logic              takeBranch;

   assign isLoad   = (opcode == rvIsaPkg::opLoad);
   assign isAluOp  = (opcode == rvIsaPkg::opAluImm) || (opcode == rvIsaPkg::opAluReg);
   assign isStore  = (opcode == rvIsaPkg::opStore);
   assign isBranch = (opcode == rvIsaPkg::opBranch);
   assign isJalr   = (opcode == rvIsaPkg::opJalr);
   assign isJal    = (opcode == rvIsaPkg::opJal);
   assign isAuipc  = (opcode == rvIsaPkg::opAuipc);
   assign isLui    = (opcode == rvIsaPkg::opLui);

   // ******************************
   // PC arithmetic
   // ******************************
   assign pcPlus4      = pc + 32'd4;
   // One adder serves branches, JAL and AUIPC
   assign branchTarget = pc + (isJal ? immJ : (isAuipc ? immU : immB));
   assign takeBranch   = isJal || (isBranch && predicate);

   // Strobes decoded straight from the one-hot state
   assign memRstrb = (state == coreCfgPkg::stFetchInstr) || (state == coreCfgPkg::stLoad);
   assign memWmask = {4{state == coreCfgPkg::stStore}}; // Word stores only
   assign aluWr    = (state == coreCfgPkg::stExecute) && isAluOp;
   // Single-cycle results write in execute, ALU and load results once settled
   assign writeBack = ((state == coreCfgPkg::stExecute) && (isLui || isAuipc || isJal || isJalr))
                    || ((state == coreCfgPkg::stWaitAluOrData) && !aluBusy && !memRbusy);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state   <= coreCfgPkg::stWaitIoStore; // Waits for memWbusy low first
         pc      <= resetAddr;
         memAddr <= resetAddr;
      end else begin
         case (state)
            coreCfgPkg::stFetchInstr: state <= coreCfgPkg::stWaitInstr;
            coreCfgPkg::stWaitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata; // Latch for the decoder
                  state <= coreCfgPkg::stFetchRegs;
               end
            end
            coreCfgPkg::stFetchRegs: state <= coreCfgPkg::stExecute;
            coreCfgPkg::stExecute: begin
               pc <= isJalr ? aluPlus : (takeBranch ? branchTarget : pcPlus4);
               // Data address for memory ops, next fetch address otherwise
               memAddr <= (isJalr || isAluOp || isStore || isLoad) ? aluPlus :
                          (takeBranch ? branchTarget : pcPlus4);
               if (isStore) begin
                  state <= coreCfgPkg::stStore;
               end else if (isAluOp) begin
                  state <= coreCfgPkg::stWaitAluOrData;
               end else if (isLoad) begin
                  state <= coreCfgPkg::stLoad;
               end else begin
                  state <= coreCfgPkg::stFetchInstr; // Jumps, branches, LUI, AUIPC
               end
            end
            coreCfgPkg::stLoad:  state <= coreCfgPkg::stWaitAluOrData;
            coreCfgPkg::stStore: state <= coreCfgPkg::stWaitIoStore;
            default: begin
               // Both wait states leave once ALU and memory are idle
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  memAddr <= pc;
                  state   <= coreCfgPkg::stFetchInstr;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/coreCfgPkg.sv */
// Core configuration sizes and the one-hot control state encoding
`default_nettype none

package coreCfgPkg;

   localparam int xlen    = 32; // Data and address width
   localparam int regIdxW = 5;  // 32 registers
   localparam int shamtW  = 5;  // Shift amount 0 to 31

   // One-hot control states, one bit per state
   typedef enum logic [7:0] {
      stFetchInstr    = 8'b0000_0001, // Instruction read strobe
      stWaitInstr     = 8'b0000_0010, // Wait for instruction word
      stFetchRegs     = 8'b0000_0100, // Register file read
      stExecute       = 8'b0000_1000,
      stLoad          = 8'b0001_0000, // Data read strobe
      stWaitAluOrData = 8'b0010_0000, // Shift stepping or load data
      stStore         = 8'b0100_0000, // Write mask active
      stWaitIoStore   = 8'b1000_0000  // Write completion, also reset state
   } stateT;

endpackage

`default_nettype wire

/* hdl/femtoCore.sv */
// Multi-cycle RV32I core top level joining decoder, registers, ALU and sequencer
`default_nettype none

module femtoCore #(
   parameter logic [coreCfgPkg::xlen-1:0] resetAddr = '0
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [coreCfgPkg::xlen-1:0] memRdata,
   input  logic                        memRbusy,
   input  logic                        memWbusy,
   output logic [coreCfgPkg::xlen-1:0] memAddr,
   output logic [coreCfgPkg::xlen-1:0] memWdata,
   output logic [3:0]                  memWmask,
   output logic                        memRstrb
);

   logic [coreCfgPkg::xlen-1:0]    instr;
   logic [coreCfgPkg::regIdxW-1:0] rd;
   logic [coreCfgPkg::regIdxW-1:0] rs1;
   logic [coreCfgPkg::regIdxW-1:0] rs2;
   rvIsaPkg::aluFnT                funct3;
   logic                           subSra;
   logic [coreCfgPkg::xlen-1:0]    immI;
   logic [coreCfgPkg::xlen-1:0]    immS;
   logic [coreCfgPkg::xlen-1:0]    immB;
   logic [coreCfgPkg::xlen-1:0]    immU;
   logic [coreCfgPkg::xlen-1:0]    immJ;
   rvIsaPkg::opcodeT               opcode;
   logic [coreCfgPkg::xlen-1:0]    rs1Data;
   logic [coreCfgPkg::xlen-1:0]    rs2Data;
   logic [coreCfgPkg::xlen-1:0]    aluIn2;
   logic [coreCfgPkg::xlen-1:0]    aluOut;
   logic [coreCfgPkg::xlen-1:0]    aluPlus;
   logic                           aluBusy;
   logic                           predicate;
   logic                           aluWr;
   logic                           writeBack;
   logic [coreCfgPkg::xlen-1:0]    wbData;
   logic [coreCfgPkg::xlen-1:0]    pcPlus4;       // Return address for jumps
   logic [coreCfgPkg::xlen-1:0]    branchTarget;

   assign memWdata = rs2Data; // Full word store data

   // ******************************
   // Operand and write-back muxes
   // ******************************
   always_comb begin
      case (opcode)
         rvIsaPkg::opAluReg, rvIsaPkg::opBranch: aluIn2 = rs2Data;
         rvIsaPkg::opStore:                      aluIn2 = immS;  // Store address offset
         default:                                aluIn2 = immI;  // OP-IMM, load, JALR
      endcase
   end

   always_comb begin
      case (opcode)
         rvIsaPkg::opLui:                        wbData = immU;
         rvIsaPkg::opAluImm, rvIsaPkg::opAluReg: wbData = aluOut;
         rvIsaPkg::opAuipc:                      wbData = branchTarget; // PC + immU
         rvIsaPkg::opJal, rvIsaPkg::opJalr:      wbData = pcPlus4;
         rvIsaPkg::opLoad:                       wbData = memRdata;
         default:                                wbData = '0;
      endcase
   end

   instrDecoder uDecoder (
      .instr(instr), .rd(rd), .rs1(rs1), .rs2(rs2), .funct3(funct3), .subSra(subSra),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ), .opcode(opcode)
   );

   regFile uRegFile (
      .clk(clk), .rs1(rs1), .rs2(rs2), .rd(rd), .writeBack(writeBack), .wbData(wbData),
      .rs1Data(rs1Data), .rs2Data(rs2Data)
   );

   // First operand is always rs1
   alu uAlu (
      .clk(clk), .reset(reset), .aluWr(aluWr), .in1(rs1Data), .in2(aluIn2),
      .funct3(funct3), .subSra(subSra), .isAluReg(opcode == rvIsaPkg::opAluReg),
      .aluOut(aluOut), .aluPlus(aluPlus), .aluBusy(aluBusy), .predicate(predicate)
   );

   controlSeq #(.resetAddr(resetAddr)) uControlSeq (
      .clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .opcode(opcode), .immB(immB), .immJ(immJ), .immU(immU),
      .aluPlus(aluPlus), .aluBusy(aluBusy), .predicate(predicate),
      .instr(instr), .pc(), .pcPlus4(pcPlus4), .branchTarget(branchTarget),
      .memAddr(memAddr), .memRstrb(memRstrb), .memWmask(memWmask),
      .aluWr(aluWr), .writeBack(writeBack)
   );

endmodule

`default_nettype wire

/* hdl/instrDecoder.sv */
// Instruction decoder forming register indices, immediates and opcode class
`default_nettype none

module instrDecoder (
   input  logic [coreCfgPkg::xlen-1:0]    instr,
   output logic [coreCfgPkg::regIdxW-1:0] rd,
   output logic [coreCfgPkg::regIdxW-1:0] rs1,
   output logic [coreCfgPkg::regIdxW-1:0] rs2,
   output rvIsaPkg::aluFnT                funct3,
   output logic                           subSra,
   output logic [coreCfgPkg::xlen-1:0]    immI,
   output logic [coreCfgPkg::xlen-1:0]    immS,
   output logic [coreCfgPkg::xlen-1:0]    immB,
   output logic [coreCfgPkg::xlen-1:0]    immU,
   output logic [coreCfgPkg::xlen-1:0]    immJ,
   output rvIsaPkg::opcodeT               opcode
);

   // ******************************
   // Register fields
   // ******************************
   assign rd  = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];

   assign funct3 = rvIsaPkg::aluFnT'(instr[14:12]);
   assign subSra = instr[30]; // SUB for OP, SRA for both shift forms

   // ******************************
   // Immediates, all sign extended from bit 31
   // ******************************
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};                       // Upper 20 bits
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Opcode class from instr[6:2]
   // Low two bits are always 11 for RV32I so they are not checked
   assign opcode = rvIsaPkg::opcodeT'(instr[6:2]);

endmodule

`default_nettype wire

/* hdl/regFile.sv */
// Register file with two registered read ports and one write port
`default_nettype none

module regFile (
   input  logic                           clk,
   input  logic [coreCfgPkg::regIdxW-1:0] rs1,
   input  logic [coreCfgPkg::regIdxW-1:0] rs2,
   input  logic [coreCfgPkg::regIdxW-1:0] rd,
   input  logic                           writeBack,
   input  logic [coreCfgPkg::xlen-1:0]    wbData,
   output logic [coreCfgPkg::xlen-1:0]    rs1Data,
   output logic [coreCfgPkg::xlen-1:0]    rs2Data
);

   logic [coreCfgPkg::xlen-1:0] regs [2**coreCfgPkg::regIdxW];

   // Both ports read every cycle, data valid one cycle later
   always_ff @(posedge clk) begin
      rs1Data <= regs[rs1];
      rs2Data <= regs[rs2];
      if (writeBack && (rd != '0)) begin
         regs[rd] <= wbData; // x0 never written, stays zero
      end
   end

   // x0 starts at zero and is never touched afterwards
   initial regs[0] = '0;

endmodule

`default_nettype wire

/* hdl/rvIsaPkg.sv */
// RV32I instruction-set encodings shared by the decoder and the ALU
`default_nettype none

package rvIsaPkg;

   // ******************************
   // Major opcode classes, instr[6:2]
   // ******************************
   typedef enum logic [4:0] {
      opLoad   = 5'b00000, // LW
      opAluImm = 5'b00100, // OP-IMM
      opAuipc  = 5'b00101,
      opStore  = 5'b01000, // SW
      opAluReg = 5'b01100, // OP
      opLui    = 5'b01101,
      opBranch = 5'b11000, // Six conditional branches
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcodeT;

   // ALU function codes from funct3
   typedef enum logic [2:0] {
      fnAdd  = 3'b000, // ADD or SUB
      fnSll  = 3'b001,
      fnSlt  = 3'b010,
      fnSltu = 3'b011,
      fnXor  = 3'b100,
      fnSrx  = 3'b101, // SRL or SRA, picked by instr[30]
      fnOr   = 3'b110,
      fnAnd  = 3'b111
   } aluFnT;

   // Branch conditions, same funct3 field
   typedef enum logic [2:0] {
      brEq  = 3'b000,
      brNe  = 3'b001,
      brLt  = 3'b100,
      brGe  = 3'b101,
      brLtu = 3'b110,
      brGeu = 3'b111
   } branchFnT;

endpackage

`default_nettype wire

/* testbench/femtoCore_properties.sv */
// Memory port assertions for the RV32I core, bound to its top level
`default_nettype none

module femtoCoreProperties (
   input logic        clk,
   input logic        reset,
   input logic [31:0] memAddr,
   input logic [3:0]  memWmask,
   input logic        memRstrb
);
   timeunit 1ns;
   timeprecision 100ps;

   // Word stores only, so no partial lane mask
   assert property (@(posedge clk) disable iff (!reset)
      (memWmask == 4'h0) || (memWmask == 4'hF))
      else $error("write mask is neither empty nor full");

   // ******************************
   // Read and write never overlap
   // ******************************
   assert property (@(posedge clk) disable iff (!reset) !(memRstrb && (memWmask != 4'h0)))
      else $error("read strobe and write mask active in the same cycle");

   assert property (@(posedge clk) disable iff (!reset) memRstrb |-> (memAddr[1:0] == 2'b00))
      else $error("read address is not word aligned");

endmodule

bind femtoCore femtoCoreProperties uProps (
   .clk(clk), .reset(reset), .memAddr(memAddr), .memWmask(memWmask), .memRstrb(memRstrb)
);

`default_nettype wire

/* testbench/golden_program.txt */
// @000 header: program word count, expected store count
// @010 program words from address 0; @200 expected stores as: testId address data
@000
00000070 00000025
@010
FF900093 00500113 30000F93 002081B3 003FA023 402081B3 003FA223 0020A1B3
003FA423 0020B1B3 003FA623 0020C1B3 003FA823 0020E1B3 003FAA23 0020F1B3
003FAC23 06408193 003FAE23 FFF12193 023FA023 FFF13193 023FA223 FFF0C193
023FA423 03016193 023FA623 0F00F193 023FA823 80000237 01120213 00400293
00021193 023FAA23 00121193 023FAC23 01F21193 023FAE23 005211B3 043FA023
00125193 043FA223 01F25193 043FA423 005251B3 043FA623 40025193 043FA823
40125193 043FAA23 41F25193 043FAC23 405251B3 043FAE23 01000313 00210463
00130313 00208463 00230313 066FA023 02000313 00209463 00130313 00211463
00230313 066FA223 03000313 0020C463 00130313 00114463 00230313 066FA423
04000313 00115463 00130313 0020D463 00230313 066FA623 05000313 00116463
00130313 0020E463 00230313 066FA823 06000313 0020F463 00130313 00117463
00230313 066FAA23 123453B7 067FAC23 00001397 067FAE23 0080046F 05500413
088FA023 00000517 00C505E7 06600593 08BFA223 20000613 00162023 00462223
00062683 08DFA423 00462703 08EFA623 00062003 00108013 080FA823 0000006F
@200
0 00000300 FFFFFFFE  0 00000304 FFFFFFF4  0 00000308 00000001  0 0000030C 00000000
0 00000310 FFFFFFFC  0 00000314 FFFFFFFD  0 00000318 00000001  0 0000031C 0000005D
0 00000320 00000000  0 00000324 00000001  0 00000328 00000006  0 0000032C 00000035
0 00000330 000000F0
1 00000334 80000011  1 00000338 00000022  1 0000033C 80000000  1 00000340 00000110
1 00000344 40000008  1 00000348 00000001  1 0000034C 08000001  1 00000350 80000011
1 00000354 C0000008  1 00000358 FFFFFFFF  1 0000035C F8000001
2 00000360 00000012  2 00000364 00000022  2 00000368 00000032  2 0000036C 00000042
2 00000370 00000052  2 00000374 00000062
3 00000378 12345000  3 0000037C 00001170  3 00000380 0000017C  3 00000384 0000018C
4 00000388 FFFFFFF9  4 0000038C 80000011  4 00000390 00000000

/* testbench/tbFemtoCore.sv */
// Testbench for the multi-cycle RV32I core with a randomly stalling memory model
`default_nettype none

module tbFemtoCore;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int memWords = 256;   // 1 KiB word memory
   localparam int progBase = 'h010; // Program words inside the golden image
   localparam int expBase  = 'h200; // Expected store triples inside the golden image
   localparam logic [31:0] sigBase = 32'h0000_0300; // Signature region start

   logic        clk;
   logic        reset;
   logic [31:0] memRdata = '0;
   logic        memRbusy = 1'b0;
   logic        memWbusy = 1'b0;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic        memRstrb;

   logic [31:0] golden [1024];          // Header, program and expected stores
   logic [31:0] mem [memWords];
   string       testNames [5] = '{"aluOps", "shifts", "branches", "jumps", "loadStore"};
   int          testErrors [5] = '{0, 0, 0, 0, 0};
   int          progLen = 0;
   int          expCount = 0;
   int          expIdx = 0;             // Next expected store
   int          passCount = 0;
   int          failCount = 0;
   int          extraStores = 0;        // Signature stores past the list
   bit          done = 1'b0;

   femtoCore #(.resetAddr(32'h0000_0000)) dut0 (
      .clk(clk), .reset(reset), .memRdata(memRdata), .memRbusy(memRbusy),
      .memWbusy(memWbusy), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRstrb(memRstrb)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk; // 8 ns period
   end

   // ******************************
   // Result reporting
   // ******************************
   task automatic reportTest(input int id);
      if (testErrors[id] == 0) begin
         $display("%s passed", testNames[id]);
         passCount++;
      end else begin
         $display("%s failed with %0d errors", testNames[id], testErrors[id]);
         failCount++;
      end
   endtask

   // Compare one signature store with the next expected triple
   task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
      int          id;
      logic [31:0] expAddr;
      logic [31:0] expData;
      if (expIdx >= expCount) begin
         $display("unexpected store of %08h to %08h after the last expected one", data, addr);
         extraStores++;
      end else begin
         id      = golden[expBase + 3 * expIdx];
         expAddr = golden[expBase + 3 * expIdx + 1];
         expData = golden[expBase + 3 * expIdx + 2];
         if (addr != expAddr) begin
            $display("error %s address expected %08h actual %08h", testNames[id], expAddr, addr);
            testErrors[id]++;
         end
         if (data != expData) begin
            $display("error %s data expected %08h actual %08h", testNames[id], expData, data);
            testErrors[id]++;
         end
         expIdx++;
         // Last store of a test when the next entry belongs elsewhere
         if (expIdx == expCount || golden[expBase + 3 * expIdx] != id) begin
            reportTest(id);
         end
         if (expIdx == expCount) begin
            done = 1'b1;
         end
      end
   endtask

   // ******************************
   // Memory model with random stalls
   // ******************************
   initial begin
      void'($urandom(76112)); // Seed the stall generator
      for (int i = 0; i < memWords; i++) begin
         mem[i] = 32'hA5A5_0000 | (i << 2); // Byte address as fill
      end
      $readmemh("testbench/golden_program.txt", golden);
      progLen  = golden[0];
      expCount = golden[1];
      for (int i = 0; i < progLen; i++) begin
         mem[i] = golden[progBase + i];
      end
      forever begin
         @(posedge clk);
         memRbusy <= ($urandom_range(3) == 0); // Stall about one cycle in four
         memWbusy <= ($urandom_range(3) == 0);
         if (memRstrb) begin
            memRdata <= mem[memAddr[9:2]]; // Held until the next strobe
         end
         if (memWmask == 4'hF) begin
            mem[memAddr[9:2]] <= memWdata;
            if (memAddr >= sigBase) begin
               checkStore(memAddr, memWdata);
            end
         end
      end
   end

   // ******************************
   // Reset, run and timeout
   // ******************************
   initial begin
      int cycles;
      int limit;
      reset = 1'b0;
      repeat (3) @(posedge clk);
      reset <= 1'b1;
      limit  = progLen * 40 * 4; // Worst case per word, times 4 for stalls
      cycles = 0;
      while (!done && cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      if (!done) begin
         $display("timeout after %0d cycles with %0d of %0d expected stores seen",
                  limit, expIdx, expCount);
         $display("TEST FAILED");
         $finish;
      end else begin
         $display("tests passed %0d failed %0d unexpected stores %0d",
                  passCount, failCount, extraStores);
         if (failCount == 0 && extraStores == 0) begin
            $display("TEST PASSED");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire
